// File: logic/branch_pkg.sv
// Branch unit package with widths, branch encodings and handshake payload types

package branch_pkg;

    // ------------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------------
    localparam int XLEN          = 32;
    localparam int ROB_IDX_LEN   = 4;
    // Must stay a power of two
    localparam int BU_RS_DEPTH   = 4;
    localparam int BU_RS_IDX_LEN = $clog2(BU_RS_DEPTH);

    typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;

    typedef enum logic [2:0] {
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JUMP
    } branch_type_t;

    // ------------------------------------------------------------
    // Payloads
    // ------------------------------------------------------------

    // Branch as delivered by the issue stage
    typedef struct packed {
        branch_type_t     branch_type;
        logic             rs1_ready;
        rob_idx_t         rs1_idx;
        logic [XLEN-1:0]  rs1_value;
        logic             rs2_ready;
        rob_idx_t         rs2_idx;
        logic [XLEN-1:0]  rs2_value;
        logic [XLEN-1:0]  imm_value;
        rob_idx_t         dest_idx;
        logic [XLEN-1:0]  curr_pc;
        logic [XLEN-1:0]  pred_target;
        logic             pred_taken;
    } bu_issue_t;

    // Operands from the station to the branch logic
    typedef struct packed {
        logic [BU_RS_IDX_LEN-1:0] entry_idx;
        branch_type_t             branch_type;
        logic [XLEN-1:0]          rs1;
        logic [XLEN-1:0]          rs2;
        logic [XLEN-1:0]          imm;
        logic [XLEN-1:0]          curr_pc;
        logic [XLEN-1:0]          pred_target;
        logic                     pred_taken;
    } bu_op_t;

    // Resolved branch on its way back to the station
    typedef struct packed {
        logic [BU_RS_IDX_LEN-1:0] entry_idx;
        logic                     mispredicted;
        logic                     taken;
        logic [XLEN-1:0]          target;
    } bu_res_t;

    typedef struct packed {
        rob_idx_t         rob_idx;
        logic [XLEN-1:0]  res_value;
        logic             mispredicted;
        logic             taken;
    } cdb_data_t;

endpackage

// File: logic/spill_cell.sv
// Two-slot valid/ready skid buffer that registers both the data and the ready path
`timescale 1ns/1ps

module spill_cell #(
    parameter type DATA_T = logic
) (
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  flush_i,

    input  logic  valid_i,
    output logic  ready_o,
    input  DATA_T data_i,

    output logic  valid_o,
    input  logic  ready_i,
    output DATA_T data_o
);

    logic  valid_q;
    logic  skid_valid_q;
    DATA_T data_q;
    DATA_T skid_q;
    logic  in_fire;
    logic  load_out;

    assign in_fire  = valid_i && ready_o;
    // Output slot is empty or drains this cycle
    assign load_out = !valid_q || ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            valid_q      <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (load_out) begin
            valid_q      <= skid_valid_q || in_fire;
            skid_valid_q <= 1'b0;
        end else if (in_fire) begin
            skid_valid_q <= 1'b1;
        end
    end

    // Skid slot first, so order is kept
    always_ff @(posedge clk_i) begin
        if (load_out) begin
            data_q <= skid_valid_q ? skid_q : data_i;
        end
        if (!load_out && in_fire) begin
            skid_q <= data_i;
        end
    end

    assign ready_o = !skid_valid_q;
    assign valid_o = valid_q;
    assign data_o  = data_q;

    a_hold_stalled : assert property (
        @(posedge clk_i) disable iff (reset_i)
        valid_o && !ready_i && !flush_i |=> valid_o && $stable(data_o)
    ) else $error("spill_cell output changed while stalled");

endmodule

// File: logic/branch_logic.sv
// Combinational branch resolution: condition, target and misprediction check
`timescale 1ns/1ps

module branch_logic import branch_pkg::*; (
    input  bu_op_t  op_i,
    output bu_res_t res_o
);

    logic            taken;
    logic [XLEN-1:0] target;
    logic            wrong_dir;
    logic            wrong_tgt;

    // ------------------------------------------------------------
    // Condition evaluation
    // ------------------------------------------------------------
    always_comb begin
        case (op_i.branch_type)
            BEQ:     taken = (op_i.rs1 == op_i.rs2);
            BNE:     taken = (op_i.rs1 != op_i.rs2);
            BLT:     taken = ($signed(op_i.rs1) < $signed(op_i.rs2));
            BGE:     taken = ($signed(op_i.rs1) >= $signed(op_i.rs2));
            BLTU:    taken = (op_i.rs1 < op_i.rs2);
            BGEU:    taken = (op_i.rs1 >= op_i.rs2);
            JUMP:    taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // Jumps share the PC-relative adder
    assign target = op_i.curr_pc + op_i.imm;

    // Compare against what the front end assumed
    assign wrong_dir = (op_i.pred_taken != taken);
    assign wrong_tgt = (op_i.pred_target != target);

    assign res_o.entry_idx    = op_i.entry_idx;
    assign res_o.mispredicted = wrong_dir || wrong_tgt;
    assign res_o.taken        = taken;
    assign res_o.target       = target;

endmodule

// File: logic/branch_rs.sv
// Branch reservation station with CDB snooping, in-order-by-index dispatch and CDB retire
`timescale 1ns/1ps

module branch_rs import branch_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      flush_i,

    input  logic      issue_valid_i,
    output logic      issue_ready_o,
    input  bu_issue_t issue_data_i,

    input  logic      cdb_valid_i,
    input  cdb_data_t cdb_data_i,

    output logic      bu_valid_o,
    input  logic      bu_ready_i,
    output bu_op_t    bu_op_o,

    input  logic      res_valid_i,
    output logic      res_ready_o,
    input  bu_res_t   res_i,

    output logic      cdb_valid_o,
    input  logic      cdb_ready_i,
    output cdb_data_t cdb_data_o
);

    typedef enum logic [1:0] {
        ST_FREE,
        ST_WAITING,
        ST_DISPATCHED,
        ST_DONE
    } entry_state_t;

    entry_state_t             state_q [BU_RS_DEPTH];
    bu_issue_t                ent_q [BU_RS_DEPTH];
    logic                     res_mis_q [BU_RS_DEPTH];
    logic                     res_taken_q [BU_RS_DEPTH];
    logic [XLEN-1:0]          res_target_q [BU_RS_DEPTH];

    logic [BU_RS_DEPTH-1:0]   free_vec;
    logic [BU_RS_DEPTH-1:0]   ready_vec;
    logic [BU_RS_DEPTH-1:0]   done_vec;
    logic [BU_RS_DEPTH-1:0]   snoop_rs1;
    logic [BU_RS_DEPTH-1:0]   snoop_rs2;
    logic                     issue_snoop_rs1;
    logic                     issue_snoop_rs2;
    logic [BU_RS_IDX_LEN-1:0] free_idx;
    logic [BU_RS_IDX_LEN-1:0] disp_idx;
    logic [BU_RS_IDX_LEN-1:0] cdb_idx;
    logic                     issue_fire;
    logic                     bu_fire;
    logic                     cdb_fire;

    // Lowest set bit wins
    function automatic logic [BU_RS_IDX_LEN-1:0] lowest_idx(input logic [BU_RS_DEPTH-1:0] vec);
        logic [BU_RS_IDX_LEN-1:0] idx;
        idx = '0;
        for (int i = BU_RS_DEPTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = BU_RS_IDX_LEN'(i);
            end
        end
        return idx;
    endfunction

    // ------------------------------------------------------------
    // Entry status and selection
    // ------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < BU_RS_DEPTH; i++) begin
            free_vec[i]  = (state_q[i] == ST_FREE);
            ready_vec[i] = (state_q[i] == ST_WAITING) && ent_q[i].rs1_ready
                           && ent_q[i].rs2_ready;
            done_vec[i]  = (state_q[i] == ST_DONE);
            snoop_rs1[i] = cdb_valid_i && !ent_q[i].rs1_ready
                           && (ent_q[i].rs1_idx == cdb_data_i.rob_idx);
            snoop_rs2[i] = cdb_valid_i && !ent_q[i].rs2_ready
                           && (ent_q[i].rs2_idx == cdb_data_i.rob_idx);
        end
    end

    // Operand broadcast in the same cycle as the issue
    assign issue_snoop_rs1 = cdb_valid_i && !issue_data_i.rs1_ready
                             && (issue_data_i.rs1_idx == cdb_data_i.rob_idx);
    assign issue_snoop_rs2 = cdb_valid_i && !issue_data_i.rs2_ready
                             && (issue_data_i.rs2_idx == cdb_data_i.rob_idx);

    assign free_idx = lowest_idx(free_vec);
    assign disp_idx = lowest_idx(ready_vec);
    assign cdb_idx  = lowest_idx(done_vec);

    assign issue_ready_o = |free_vec;
    assign bu_valid_o    = |ready_vec;
    assign cdb_valid_o   = |done_vec;
    // Slot is already reserved by the dispatch
    assign res_ready_o   = 1'b1;

    assign issue_fire = issue_valid_i && issue_ready_o;
    assign bu_fire    = bu_valid_o && bu_ready_i;
    assign cdb_fire   = cdb_valid_o && cdb_ready_i;

    // Operands to the branch logic
    assign bu_op_o.entry_idx   = disp_idx;
    assign bu_op_o.branch_type = ent_q[disp_idx].branch_type;
    assign bu_op_o.rs1         = ent_q[disp_idx].rs1_value;
    assign bu_op_o.rs2         = ent_q[disp_idx].rs2_value;
    assign bu_op_o.imm         = ent_q[disp_idx].imm_value;
    assign bu_op_o.curr_pc     = ent_q[disp_idx].curr_pc;
    assign bu_op_o.pred_target = ent_q[disp_idx].pred_target;
    assign bu_op_o.pred_taken  = ent_q[disp_idx].pred_taken;

    // Not-taken branches write the fall-through address
    assign cdb_data_o.rob_idx      = ent_q[cdb_idx].dest_idx;
    assign cdb_data_o.res_value    = res_taken_q[cdb_idx] ? res_target_q[cdb_idx]
                                                          : ent_q[cdb_idx].curr_pc + XLEN'(4);
    assign cdb_data_o.mispredicted = res_mis_q[cdb_idx];
    assign cdb_data_o.taken        = res_taken_q[cdb_idx];

    // ------------------------------------------------------------
    // Entry state machine
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            for (int i = 0; i < BU_RS_DEPTH; i++) begin
                state_q[i] <= ST_FREE;
            end
        end else begin
            for (int i = 0; i < BU_RS_DEPTH; i++) begin
                case (state_q[i])
                    ST_FREE: begin
                        if (issue_fire && free_idx == BU_RS_IDX_LEN'(i)) begin
                            state_q[i] <= ST_WAITING;
                        end
                    end
                    ST_WAITING: begin
                        if (bu_fire && disp_idx == BU_RS_IDX_LEN'(i)) begin
                            state_q[i] <= ST_DISPATCHED;
                        end
                    end
                    ST_DISPATCHED: begin
                        if (res_valid_i && res_i.entry_idx == BU_RS_IDX_LEN'(i)) begin
                            state_q[i] <= ST_DONE;
                        end
                    end
                    default: begin
                        if (cdb_fire && cdb_idx == BU_RS_IDX_LEN'(i)) begin
                            state_q[i] <= ST_FREE;
                        end
                    end
                endcase
            end
        end
    end

    // Entry payload, operand capture and result write-back
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < BU_RS_DEPTH; i++) begin
            if (issue_fire && state_q[i] == ST_FREE && free_idx == BU_RS_IDX_LEN'(i)) begin
                ent_q[i] <= issue_data_i;
                if (issue_snoop_rs1) begin
                    ent_q[i].rs1_ready <= 1'b1;
                    ent_q[i].rs1_value <= cdb_data_i.res_value;
                end
                if (issue_snoop_rs2) begin
                    ent_q[i].rs2_ready <= 1'b1;
                    ent_q[i].rs2_value <= cdb_data_i.res_value;
                end
            end else if (state_q[i] == ST_WAITING) begin
                if (snoop_rs1[i]) begin
                    ent_q[i].rs1_ready <= 1'b1;
                    ent_q[i].rs1_value <= cdb_data_i.res_value;
                end
                if (snoop_rs2[i]) begin
                    ent_q[i].rs2_ready <= 1'b1;
                    ent_q[i].rs2_value <= cdb_data_i.res_value;
                end
            end
            if (res_valid_i && state_q[i] == ST_DISPATCHED
                    && res_i.entry_idx == BU_RS_IDX_LEN'(i)) begin
                res_mis_q[i]    <= res_i.mispredicted;
                res_taken_q[i]  <= res_i.taken;
                res_target_q[i] <= res_i.target;
            end
        end
    end

    // Results come back through the spill cell, so check the slot owner
    a_res_to_dispatched : assert property (
        @(posedge clk_i) disable iff (reset_i)
        res_valid_i |-> state_q[res_i.entry_idx] == ST_DISPATCHED
    ) else $error("branch result for an entry that is not dispatched");

    a_full_blocks_issue : assert property (
        @(posedge clk_i) disable iff (reset_i)
        issue_fire && $countones(free_vec) == 1 && !cdb_fire && !flush_i |=> !issue_ready_o
    ) else $error("issue accepted with every entry busy");

endmodule

// File: logic/branch_unit.sv
// Branch unit top joining the station, branch logic and the result and CDB buffers
`timescale 1ns/1ps

module branch_unit import branch_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      flush_i,

    input  logic      issue_valid_i,
    output logic      issue_ready_o,
    input  bu_issue_t issue_data_i,

    input  logic      cdb_valid_i,
    input  cdb_data_t cdb_data_i,

    input  logic      cdb_ready_i,
    output logic      cdb_valid_o,
    output cdb_data_t cdb_data_o
);

    // Station to branch logic
    logic      bu_valid;
    logic      bu_ready;
    bu_op_t    bu_op;
    bu_res_t   logic_res;

    // Result cell back to the station
    logic      res_valid;
    logic      res_ready;
    bu_res_t   res_data;

    // Station to the CDB cell
    logic      rs_cdb_valid;
    logic      rs_cdb_ready;
    cdb_data_t rs_cdb_data;

    // ------------------------------------------------------------
    // Reservation station
    // ------------------------------------------------------------
    branch_rs u_branch_rs (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_data_i  (issue_data_i),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_data_i    (cdb_data_i),
        .bu_valid_o    (bu_valid),
        .bu_ready_i    (bu_ready),
        .bu_op_o       (bu_op),
        .res_valid_i   (res_valid),
        .res_ready_o   (res_ready),
        .res_i         (res_data),
        .cdb_valid_o   (rs_cdb_valid),
        .cdb_ready_i   (rs_cdb_ready),
        .cdb_data_o    (rs_cdb_data)
    );

    // ------------------------------------------------------------
    // Resolution path
    // ------------------------------------------------------------
    branch_logic u_branch_logic (
        .op_i  (bu_op),
        .res_o (logic_res)
    );

    spill_cell #(
        .DATA_T (bu_res_t)
    ) u_res_cell (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .valid_i (bu_valid),
        .ready_o (bu_ready),
        .data_i  (logic_res),
        .valid_o (res_valid),
        .ready_i (res_ready),
        .data_o  (res_data)
    );

    // Output register towards the CDB
    spill_cell #(
        .DATA_T (cdb_data_t)
    ) u_cdb_cell (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .valid_i (rs_cdb_valid),
        .ready_o (rs_cdb_ready),
        .data_i  (rs_cdb_data),
        .valid_o (cdb_valid_o),
        .ready_i (cdb_ready_i),
        .data_o  (cdb_data_o)
    );

endmodule

// File: testbench/tb_branch_tasks.svh
// Branch unit testbench tasks for stimulus, the result model, checking and directed tests
`ifndef TB_BRANCH_TASKS_SVH
`define TB_BRANCH_TASKS_SVH

// ------------------------------------------------------------
// Checking and the result model
// ------------------------------------------------------------
task automatic stop_run(input string why);
    $display("Test failed");
    $fatal(1, "%s", why);
endtask

task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (expected !== actual) begin
        $display("FAILED time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
        stop_run("a DUT output did not match its expected value");
    end
endtask

task automatic model_result(input bu_issue_t d, output cdb_data_t w);
    logic [XLEN-1:0] target;
    logic            lt_s;
    logic            taken;
    target = d.curr_pc + d.imm_value;
    // Signed order is the unsigned one flipped when the sign bits differ
    lt_s = (d.rs1_value < d.rs2_value) ^ (d.rs1_value[XLEN-1] ^ d.rs2_value[XLEN-1]);
    case (d.branch_type)
        BEQ:     taken = (d.rs1_value == d.rs2_value);
        BNE:     taken = (d.rs1_value != d.rs2_value);
        BLT:     taken = lt_s;
        BGE:     taken = !lt_s;
        BLTU:    taken = (d.rs1_value < d.rs2_value);
        BGEU:    taken = !(d.rs1_value < d.rs2_value);
        default: taken = 1'b1;
    endcase
    w.rob_idx      = d.dest_idx;
    w.taken        = taken;
    w.mispredicted = (d.pred_taken != taken) || (d.pred_target != target);
    w.res_value    = taken ? target : d.curr_pc + 32'd4;
endtask

task automatic expect_word(input bu_issue_t d);
    cdb_data_t w;
    model_result(d, w);
    if (exp_pending[w.rob_idx]) begin
        stop_run("a ROB tag was reused while its branch was still in flight");
    end
    exp_word[w.rob_idx]    = w;
    exp_pending[w.rob_idx] = 1'b1;
    pending_count++;
endtask

task automatic record_output(input cdb_data_t w);
    cdb_data_t e;
    if (!exp_pending[w.rob_idx]) begin
        stop_run("the CDB output carried a ROB tag with no resolvable branch");
    end
    e = exp_word[w.rob_idx];
    check_value("cdb_data_o.taken", 64'(e.taken), 64'(w.taken));
    check_value("cdb_data_o.mispredicted", 64'(e.mispredicted), 64'(w.mispredicted));
    check_value("cdb_data_o.res_value", 64'(e.res_value), 64'(w.res_value));
    exp_pending[w.rob_idx] = 1'b0;
    pending_count--;
endtask

// ------------------------------------------------------------
// Stimulus
// ------------------------------------------------------------
task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic make_branch(input branch_type_t bt, output bu_issue_t d);
    logic [11:0] offset;
    offset        = 12'($urandom) & 12'hffe;
    d             = '0;
    d.branch_type = bt;
    d.rs1_ready   = 1'b1;
    d.rs2_ready   = 1'b1;
    d.rs1_value   = $urandom;
    d.rs2_value   = $urandom;
    // Word-aligned PC and a short signed offset
    d.curr_pc     = $urandom & 32'hffff_fffc;
    d.imm_value   = {{20{offset[11]}}, offset};
    d.dest_idx    = next_tag;
    next_tag++;
    d.pred_taken  = 1'($urandom);
    d.pred_target = d.curr_pc + d.imm_value;
endtask

task automatic try_issue(input bu_issue_t d, output bit accepted);
    issue_valid = 1'b1;
    issue_data  = d;
    @(negedge clk);
    accepted = issue_ready;
    next_cycle();
    issue_valid = 1'b0;
endtask

task automatic issue_branch(input bu_issue_t d);
    bit accepted;
    accepted = 1'b0;
    while (!accepted) begin
        try_issue(d, accepted);
    end
endtask

task automatic send_cdb(input rob_idx_t tag, input logic [XLEN-1:0] value);
    cdb_in_data           = '0;
    cdb_in_data.rob_idx   = tag;
    cdb_in_data.res_value = value;
    cdb_in_valid          = 1'b1;
    next_cycle();
    cdb_in_valid = 1'b0;
endtask

task automatic wait_drain();
    while (pending_count != 0) begin
        next_cycle();
    end
endtask

// ------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------
task automatic test_reset_and_conditions();
    bu_issue_t d;
    check_value("cdb_valid_o", 64'd0, 64'(cdb_valid));
    check_value("issue_ready_o", 64'd1, 64'(issue_ready));
    for (int t = 0; t < 7; t++) begin
        for (int v = 0; v < 3; v++) begin
            make_branch(branch_type_t'(t), d);
            // Equal operands, then a negative rs1 against a positive rs2
            if (v == 1) begin
                d.rs2_value = d.rs1_value;
            end else if (v == 2) begin
                d.rs1_value[XLEN-1] = 1'b1;
                d.rs2_value[XLEN-1] = 1'b0;
            end
            expect_word(d);
            issue_branch(d);
        end
        wait_drain();
    end
endtask

task automatic test_misprediction();
    bu_issue_t d;
    cdb_data_t w;
    for (int t = 0; t < 7; t++) begin
        for (int v = 0; v < 3; v++) begin
            make_branch(branch_type_t'(t), d);
            model_result(d, w);
            // Right guess, wrong direction, right direction to a wrong target
            d.pred_taken  = (v == 1) ? !w.taken : w.taken;
            d.pred_target = d.curr_pc + d.imm_value + ((v == 2) ? 32'd8 : 32'd0);
            expect_word(d);
            issue_branch(d);
        end
        wait_drain();
    end
endtask

task automatic test_forwarding();
    bu_issue_t d;
    bu_issue_t stale;
    // rs1 late, rs2 late, both late on two tags, both late on one tag
    for (int c = 0; c < 4; c++) begin
        make_branch(BLTU, d);
        if (c == 3) begin
            d.rs2_value = d.rs1_value;
        end
        stale = d;
        if (c != 1) begin
            stale.rs1_ready = 1'b0;
            stale.rs1_idx   = 4'd5;
            stale.rs1_value = ~d.rs1_value;
        end
        if (c != 0) begin
            stale.rs2_ready = 1'b0;
            stale.rs2_idx   = (c == 3) ? 4'd5 : 4'd9;
            stale.rs2_value = ~d.rs2_value;
        end
        issue_branch(stale);
        // The monitor rejects any output while an operand is missing
        repeat (8) next_cycle();
        if (c == 2) begin
            send_cdb(4'd5, d.rs1_value);
            repeat (8) next_cycle();
        end
        expect_word(d);
        if (c == 1 || c == 2) begin
            send_cdb(4'd9, d.rs2_value);
        end else begin
            send_cdb(4'd5, d.rs1_value);
        end
        wait_drain();
    end
    // Operand broadcast in the issue cycle
    make_branch(BGE, d);
    stale           = d;
    stale.rs1_ready = 1'b0;
    stale.rs1_idx   = 4'd5;
    stale.rs1_value = ~d.rs1_value;
    expect_word(d);
    cdb_in_data           = '0;
    cdb_in_data.rob_idx   = 4'd5;
    cdb_in_data.res_value = d.rs1_value;
    cdb_in_valid          = 1'b1;
    issue_branch(stale);
    cdb_in_valid = 1'b0;
    wait_drain();
endtask

task automatic test_backpressure();
    bu_issue_t d;
    bit        accepted;
    int        count;
    count     = 0;
    accepted  = 1'b1;
    cdb_ready = 1'b0;
    while (accepted && count < 10) begin
        make_branch(BNE, d);
        try_issue(d, accepted);
        if (accepted) begin
            expect_word(d);
            count++;
        end
    end
    // Every station entry plus both slots of the output cell
    check_value("accepted branches", 64'(BU_RS_DEPTH + 2), 64'(count));
    repeat (10) begin
        next_cycle();
        check_value("issue_ready_o", 64'd0, 64'(issue_ready));
    end
    cdb_ready = 1'b1;
    wait_drain();
endtask

task automatic test_flush();
    bu_issue_t d;
    cdb_ready = 1'b0;
    // Four finished branches, then two stuck on a missing rs2
    for (int i = 0; i < 6; i++) begin
        make_branch(BLT, d);
        if (i >= 4) begin
            d.rs2_ready = 1'b0;
            d.rs2_idx   = 4'd12;
        end
        issue_branch(d);
    end
    repeat (6) next_cycle();
    flush = 1'b1;
    next_cycle();
    flush     = 1'b0;
    cdb_ready = 1'b1;
    repeat (20) begin
        @(negedge clk);
        check_value("cdb_valid_o", 64'd0, 64'(cdb_valid));
        check_value("issue_ready_o", 64'd1, 64'(issue_ready));
        next_cycle();
    end
    make_branch(JUMP, d);
    expect_word(d);
    issue_branch(d);
    wait_drain();
endtask

`endif

// File: testbench/tb_branch_unit.sv
// Branch unit testbench with clock, reset, DUT, CDB monitor, run limit and test sequence
`timescale 1ns/1ps

module tb_branch_unit import branch_pkg::*; ();

    logic      clk;
    logic      reset;
    logic      flush;
    logic      issue_valid;
    logic      issue_ready;
    bu_issue_t issue_data;
    logic      cdb_in_valid;
    cdb_data_t cdb_in_data;
    logic      cdb_ready;
    logic      cdb_valid;
    cdb_data_t cdb_data;

    // Expected CDB words, indexed by ROB tag
    cdb_data_t exp_word [2**ROB_IDX_LEN];
    logic      exp_pending [2**ROB_IDX_LEN];
    int        pending_count;
    rob_idx_t  next_tag;
    int        cycle_count = 0;

    // Output seen stalled on the previous sample
    logic      stall_seen;
    cdb_data_t held_word;

    branch_unit branch_unit_inst (
        .clk_i         (clk),
        .reset_i       (reset),
        .flush_i       (flush),
        .issue_valid_i (issue_valid),
        .issue_ready_o (issue_ready),
        .issue_data_i  (issue_data),
        .cdb_valid_i   (cdb_in_valid),
        .cdb_data_i    (cdb_in_data),
        .cdb_ready_i   (cdb_ready),
        .cdb_valid_o   (cdb_valid),
        .cdb_data_o    (cdb_data)
    );

    `include "tb_branch_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit, about four times the length of the test sequence
    initial begin
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= 2000) begin
                stop_run("timeout: the tests did not finish within 2000 cycles");
            end
        end
    end

    // ------------------------------------------------------------
    // CDB output monitor, sampled mid-cycle
    // ------------------------------------------------------------
    initial begin
        forever begin
            @(negedge clk);
            if (!reset) begin
                if (stall_seen) begin
                    check_value("cdb_valid_o", 64'd1, 64'(cdb_valid));
                    check_value("cdb_data_o", 64'(held_word), 64'(cdb_data));
                end
                stall_seen = cdb_valid && !cdb_ready && !flush;
                held_word  = cdb_data;
                if (cdb_valid && cdb_ready) begin
                    record_output(cdb_data);
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h2a62));
        reset         = 1'b1;
        flush         = 1'b0;
        issue_valid   = 1'b0;
        issue_data    = '0;
        cdb_in_valid  = 1'b0;
        cdb_in_data   = '0;
        cdb_ready     = 1'b1;
        pending_count = 0;
        next_tag      = '0;
        stall_seen    = 1'b0;
        held_word     = '0;
        for (int i = 0; i < 2**ROB_IDX_LEN; i++) begin
            exp_pending[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_and_conditions();
        test_misprediction();
        test_forwarding();
        test_backpressure();
        test_flush();

        $display("Test passed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+testbench
logic/branch_pkg.sv
logic/spill_cell.sv
logic/branch_logic.sv
logic/branch_rs.sv
logic/branch_unit.sv
testbench/tb_branch_unit.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_branch_unit
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
